// ==== Makefile ====
# Verilator build and run for the uart testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
TOP       ?= tb_uart
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the binary is the pass or fail result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/uart_core_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// uart core interface
// joins the register block to the tx and rx engines
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

interface uart_core_if #(
   parameter int DIV_W = 16
);

   logic [DIV_W-1:0] divider;  // clocks per bit
   logic             soft_clr; // one cycle, back to reset state
   logic             tx_load;  // start a frame with tx_data
   logic [7:0]       tx_data;
   logic             tx_busy;  // frame in flight
   logic [7:0]       rx_data;  // holding buffer
   logic             rx_valid;
   logic             rx_take;  // buffer read, drop valid

   // register side owns the control pulses
   modport regs_mp (
      output divider, soft_clr, tx_load, tx_data, rx_take,
      input  tx_busy, rx_data, rx_valid
   );

   modport tx_mp (
      input  divider, soft_clr, tx_load, tx_data,
      output tx_busy
   );

   modport rx_mp (
      input  divider, soft_clr, rx_take,
      output rx_data, rx_valid
   );

endinterface

`default_nettype wire

// ==== design/uart_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// uart package
// register map, bus width and status bit positions
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package uart_pkg;

   // wishbone data width
   localparam int WB_DW = 32;

   // register index, taken from wb address bits 3:2
   typedef enum logic [1:0] {
      REG_STATUS  = 2'd0, // read only
      REG_DIVIDER = 2'd1, // clocks per bit
      REG_DATA    = 2'd2, // tx on write, rx on read
      REG_CONTROL = 2'd3  // soft clear on write
   } uart_reg_e;

   // status word bits
   localparam int STAT_TX_BUSY  = 0;
   localparam int STAT_RX_VALID = 1;

   // returned by an empty data read and by control reads
   localparam logic [WB_DW-1:0] RX_EMPTY_WORD = '1;

endpackage

`default_nettype wire

// ==== design/uart_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// uart register block
// wishbone classic slave, divider register, tx/rx handshakes
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module uart_regs #(
   parameter int DIV_W     = 16,
   parameter int DIV_RESET = 4
) (
   input  logic                      clk,
   input  logic                      rstn_int,
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  uart_pkg::uart_reg_e       wb_adr,
   input  logic [uart_pkg::WB_DW-1:0] wb_dat_i,
   output logic [uart_pkg::WB_DW-1:0] wb_dat_o,
   output logic                      wb_ack,
   uart_core_if.regs_mp              core
);

   import uart_pkg::*;

   logic             req;       // live request, not yet acked
   logic             data_wr;   // write to data register
   logic             accept;    // request taken this cycle
   logic [DIV_W-1:0] divider_q;
   logic [WB_DW-1:0] rd_word;   // read mux output

   // stb stays up during the ack cycle, so mask it there
   assign req = wb_cyc & wb_stb & ~wb_ack;

   assign data_wr = wb_we & (wb_adr == REG_DATA);

   // data writes stall while a frame is still going out
   assign accept = req & ~(data_wr & core.tx_busy);

   // control pulses, all in the accept cycle
   assign core.tx_load  = accept & data_wr;
   assign core.tx_data  = wb_dat_i[7:0]; // low byte only
   assign core.rx_take  = accept & ~wb_we & (wb_adr == REG_DATA);
   assign core.soft_clr = accept & wb_we & (wb_adr == REG_CONTROL);
   assign core.divider  = divider_q;

   // divider register, soft clear restores the reset value
   always_ff @(posedge clk or negedge rstn_int) begin
      if (!rstn_int) begin
         divider_q <= DIV_W'(DIV_RESET);
      end else if (core.soft_clr) begin
         divider_q <= DIV_W'(DIV_RESET);
      end else if (accept && wb_we && wb_adr == REG_DIVIDER) begin
         divider_q <= wb_dat_i[DIV_W-1:0];
      end
   end

   // read word, picked by register index
   always_comb begin
      rd_word = '0;
      case (wb_adr)
         REG_STATUS: begin
            rd_word[STAT_TX_BUSY]  = core.tx_busy;
            rd_word[STAT_RX_VALID] = core.rx_valid;
         end
         REG_DIVIDER: rd_word = WB_DW'(divider_q); // zero extended
         REG_DATA: begin
            if (core.rx_valid) begin
               rd_word = WB_DW'(core.rx_data);
            end else begin
               rd_word = RX_EMPTY_WORD; // nothing received
            end
         end
         default: rd_word = RX_EMPTY_WORD; // control reads all ones
      endcase
   end

   // ack one clock after accept, single cycle
   always_ff @(posedge clk or negedge rstn_int) begin
      if (!rstn_int) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= accept;
      end
   end

   // read data captured alongside the ack
   always_ff @(posedge clk) begin
      if (accept && !wb_we) begin
         wb_dat_o <= rd_word;
      end
   end

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// uart receiver
// mid-bit sampling fsm with a one byte holding buffer
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
   parameter int DIV_W = 16
) (
   input  logic       clk,
   input  logic       rstn_int,
   input  logic       ser_rx,
   uart_core_if.rx_mp core
);

   typedef enum logic [1:0] {
      RX_IDLE,  // wait for falling edge
      RX_START, // half bit to mid start
      RX_DATA,  // eight samples
      RX_STOP   // one more bit, then store
   } rx_state_e;

   rx_state_e        state;
   logic             rx_meta;          // two flop synchronizer
   logic             rx_sync;
   logic [DIV_W-1:0] cnt;              // clocks in current state
   logic [2:0]       bit_idx;
   logic [7:0]       shift_q;
   logic [7:0]       buf_q;            // holding buffer
   logic             valid_q;
   logic             half_end;
   logic             full_end;

   // doubled count gets one extra bit so it cannot overflow
   assign half_end = ({cnt, 1'b0} >= {1'b0, core.divider});
   assign full_end = (cnt >= core.divider);

   always_ff @(posedge clk or negedge rstn_int) begin
      if (!rstn_int) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= ser_rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk or negedge rstn_int) begin
      if (!rstn_int) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         valid_q <= 1'b0;
      end else if (core.soft_clr) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         valid_q <= 1'b0;
      end else begin
         if (core.rx_take) valid_q <= 1'b0; // byte read out
         cnt <= cnt + DIV_W'(1);
         case (state)
            RX_IDLE: begin
               cnt <= DIV_W'(1);
               if (!rx_sync) state <= RX_START; // start edge
            end
            RX_START: begin
               if (half_end) begin
                  state   <= RX_DATA;
                  cnt     <= DIV_W'(1);
                  bit_idx <= '0;
               end
            end
            RX_DATA: begin
               if (full_end) begin
                  cnt     <= DIV_W'(1);
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7) state <= RX_STOP;
               end
            end
            default: begin
               if (full_end) begin
                  state   <= RX_IDLE;
                  valid_q <= 1'b1; // a new byte beats a same cycle take
               end
            end
         endcase
      end
   end

   // data path with the lsb arriving first
   always_ff @(posedge clk) begin
      if (state == RX_DATA && full_end) shift_q <= {rx_sync, shift_q[7:1]};
      if (state == RX_STOP && full_end) buf_q <= shift_q; // overwrites old
   end

   assign core.rx_data  = buf_q;
   assign core.rx_valid = valid_q;

endmodule

`default_nettype wire

// ==== design/uart_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// uart top level
// wishbone slave with 8N1 tx and rx
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module uart_top #(
   parameter int DIV_W     = 16,
   parameter int DIV_RESET = 4
) (
   input  logic                       clk,
   input  logic                       rstn_int,
   // wishbone classic slave
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  logic [3:0]                 wb_adr,   // byte address, word index in 3:2
   input  logic [uart_pkg::WB_DW-1:0] wb_dat_i,
   output logic [uart_pkg::WB_DW-1:0] wb_dat_o,
   output logic                       wb_ack,
   // serial line
   output logic                       ser_tx,
   input  logic                       ser_rx
);

   import uart_pkg::*;

   // register block to tx/rx wiring
   uart_core_if #(
      .DIV_W (DIV_W)
   ) core_if ();

   uart_regs #(
      .DIV_W     (DIV_W),
      .DIV_RESET (DIV_RESET)
   ) uart_regs_inst (
      .clk      (clk),
      .rstn_int (rstn_int),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (uart_reg_e'(wb_adr[3:2])), // bits 1:0 ignored, word access
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack   (wb_ack),
      .core     (core_if.regs_mp)
   );

   uart_tx #(
      .DIV_W (DIV_W)
   ) uart_tx_inst (
      .clk      (clk),
      .rstn_int (rstn_int),
      .ser_tx   (ser_tx),
      .core     (core_if.tx_mp)
   );

   uart_rx #(
      .DIV_W (DIV_W)
   ) uart_rx_inst (
      .clk      (clk),
      .rstn_int (rstn_int),
      .ser_rx   (ser_rx),
      .core     (core_if.rx_mp)
   );

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// uart transmitter
// 8N1 frame out, lsb first, divider clocks per bit
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
   parameter int DIV_W = 16
) (
   input  logic       clk,
   input  logic       rstn_int,
   output logic       ser_tx,
   uart_core_if.tx_mp core
);

   logic [9:0]       frame_q;  // stop, data, start
   logic [DIV_W-1:0] div_cnt;  // clocks into the current bit
   logic [3:0]       bit_cnt;  // bits left in the frame
   logic             bit_end;

   // last clock of a bit, a zero divider acts as one
   assign bit_end = (div_cnt >= core.divider);

   always_ff @(posedge clk or negedge rstn_int) begin
      if (!rstn_int) begin
         frame_q <= '1;     // idle line high
         div_cnt <= '0;
         bit_cnt <= '0;
      end else if (core.soft_clr) begin
         frame_q <= '1;
         div_cnt <= '0;
         bit_cnt <= '0;
      end else if (core.tx_load) begin
         frame_q <= {1'b1, core.tx_data, 1'b0};
         div_cnt <= DIV_W'(1); // start bit begins next edge
         bit_cnt <= 4'd10;
      end else if (bit_cnt != 4'd0) begin
         if (bit_end) begin
            frame_q <= {1'b1, frame_q[9:1]}; // shift right, fill idle
            div_cnt <= DIV_W'(1);
            bit_cnt <= bit_cnt - 4'd1;
         end else begin
            div_cnt <= div_cnt + DIV_W'(1);
         end
      end
   end

   // busy until the stop bit has run its full time
   assign core.tx_busy = (bit_cnt != 4'd0);

   assign ser_tx = frame_q[0];

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+test
design/uart_pkg.sv
design/uart_core_if.sv
design/uart_regs.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
test/tb_uart.sv

// ==== test/tb_uart_tasks.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// uart testbench tasks
// bus access, serial line models and directed tests
// ~~~~~~~~~~~~~~~~~~~~
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// stop at the first mismatch
task automatic check_equal(input logic [WB_DW-1:0] got, input logic [WB_DW-1:0] exp,
                           input string what);
   if (got !== exp) begin
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
   end
endtask

// returns one ns after the ack edge
task automatic wait_ack();
   do begin
      @(posedge clk);
      #1;
   end while (!wb_ack);
   last_ack_time = $time;
endtask

task automatic wb_write(input uart_reg_e idx, input logic [WB_DW-1:0] data);
   @(posedge clk);
   #DRIVE_DLY;
   wb_cyc   = 1'b1;
   wb_stb   = 1'b1;
   wb_we    = 1'b1;
   wb_adr   = {idx, 2'b00};   // word index in bits 3:2
   wb_dat_i = data;
   wait_ack();
   #(DRIVE_DLY - 1);
   wb_cyc = 1'b0;
   wb_stb = 1'b0;
   wb_we  = 1'b0;
endtask

task automatic wb_read(input uart_reg_e idx, output logic [WB_DW-1:0] data);
   @(posedge clk);
   #DRIVE_DLY;
   wb_cyc = 1'b1;
   wb_stb = 1'b1;
   wb_we  = 1'b0;
   wb_adr = {idx, 2'b00};
   wait_ack();
   data = wb_dat_o;           // valid with the ack
   #(DRIVE_DLY - 1);
   wb_cyc = 1'b0;
   wb_stb = 1'b0;
endtask

// bounded wait on one status bit
task automatic poll_status(input int bit_pos, input logic value, input int max_polls);
   logic [WB_DW-1:0] st;
   int               n;
   n = 0;
   wb_read(REG_STATUS, st);
   while (st[bit_pos] !== value && n < max_polls) begin
      wb_read(REG_STATUS, st);
      n++;
   end
   check_equal(WB_DW'(st[bit_pos]), WB_DW'(value), "status bit after polling");
endtask

// samples one frame on ser_tx at mid bit
task automatic tx_capture(input int div, output logic [7:0] data);
   int half_ns;
   int bit_ns;
   int i;
   half_ns = div * CLK_HALF;
   bit_ns  = 2 * half_ns;
   @(negedge ser_tx);          // start edge
   #(half_ns);
   check_equal(WB_DW'(ser_tx), '0, "tx start bit");
   for (i = 0; i < 8; i++) begin
      #(bit_ns);
      data[i] = ser_tx;        // lsb first
   end
   #(bit_ns);
   check_equal(WB_DW'(ser_tx), WB_DW'(1), "tx stop bit");
   stop_seen_time = $time;
endtask

// drives one frame on ser_rx and leaves the line high
task automatic rx_drive(input int div, input logic [7:0] data);
   logic [9:0] frame;
   int         i;
   frame = {1'b1, data, 1'b0};
   for (i = 0; i < 10; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      ser_rx = frame[i];
      repeat (div - 1) @(posedge clk);
   end
endtask

task automatic read_reset_values();
   logic [WB_DW-1:0] rd;
   wb_read(REG_STATUS, rd);
   check_equal(rd, '0, "status after reset");
   wb_read(REG_DIVIDER, rd);
   check_equal(rd, WB_DW'(DIV_RESET), "divider after reset");
   wb_read(REG_DATA, rd);
   check_equal(rd, RX_EMPTY_WORD, "data with nothing received");
endtask

task automatic divider_readback();
   logic [WB_DW-1:0] rd;
   int               new_div;
   new_div = $urandom_range(DIV_MAX, DIV_MIN);   // small so frames stay short
   wb_write(REG_DIVIDER, WB_DW'(new_div));
   wb_read(REG_DIVIDER, rd);
   check_equal(rd, WB_DW'(new_div), "divider readback");
   cur_div = new_div;
endtask

task automatic transmit_one_byte();
   logic [7:0]       tx_byte;
   logic [7:0]       got;
   logic [WB_DW-1:0] st;
   tx_byte = 8'($urandom);
   fork
      tx_capture(cur_div, got);
      begin
         wb_write(REG_DATA, WB_DW'(tx_byte));
         wb_read(REG_STATUS, st);
         check_equal(WB_DW'(st[STAT_TX_BUSY]), WB_DW'(1), "tx busy after data write");
      end
   join
   check_equal(WB_DW'(got), WB_DW'(tx_byte), "byte seen on ser_tx");
   poll_status(STAT_TX_BUSY, 1'b0, cur_div + 4);   // rest of the stop bit
endtask

task automatic receive_one_byte();
   logic [7:0]       rx_byte;
   logic [WB_DW-1:0] rd;
   rx_byte = 8'($urandom);
   rx_drive(cur_div, rx_byte);
   poll_status(STAT_RX_VALID, 1'b1, cur_div + 4);
   wb_read(REG_DATA, rd);
   check_equal(rd, WB_DW'(rx_byte), "received byte");
   wb_read(REG_DATA, rd);
   check_equal(rd, RX_EMPTY_WORD, "data after read out");
   wb_read(REG_STATUS, rd);
   check_equal(WB_DW'(rd[STAT_RX_VALID]), '0, "rx valid after read out");
endtask

task automatic back_to_back_writes();
   logic [7:0] b0;
   logic [7:0] b1;
   logic [7:0] g0;
   logic [7:0] g1;
   time        first_stop;
   time        second_ack;
   b0 = 8'($urandom);
   b1 = 8'($urandom);
   fork
      begin
         tx_capture(cur_div, g0);
         first_stop = stop_seen_time;
         tx_capture(cur_div, g1);
      end
      begin
         wb_write(REG_DATA, WB_DW'(b0));
         wb_write(REG_DATA, WB_DW'(b1));   // stalls while busy
         second_ack = last_ack_time;
      end
   join
   check_equal(WB_DW'(second_ack > first_stop), WB_DW'(1), "second ack after first stop bit");
   check_equal(WB_DW'(g0), WB_DW'(b0), "first back to back byte");
   check_equal(WB_DW'(g1), WB_DW'(b1), "second back to back byte");
   poll_status(STAT_TX_BUSY, 1'b0, cur_div + 4);
endtask

task automatic soft_clear_mid_frame();
   logic [WB_DW-1:0] rd;
   wb_write(REG_DATA, '0);                // zero byte keeps the line low mid frame
   repeat (3 * cur_div) @(posedge clk);   // a few bits into the frame
   wb_read(REG_STATUS, rd);
   check_equal(WB_DW'(rd[STAT_TX_BUSY]), WB_DW'(1), "tx busy before soft clear");
   wb_write(REG_CONTROL, '0);
   check_equal(WB_DW'(ser_tx), WB_DW'(1), "ser_tx after soft clear");
   wb_read(REG_STATUS, rd);
   check_equal(rd, '0, "status after soft clear");
   wb_read(REG_DIVIDER, rd);
   check_equal(rd, WB_DW'(DIV_RESET), "divider after soft clear");
   cur_div = DIV_RESET;
endtask

`endif

// ==== test/tb_uart.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// uart testbench
// clock, reset, dut and the directed test sequence
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_uart;

   import uart_pkg::*;

   localparam int DIV_W     = 16;
   localparam int DIV_RESET = 4;
   localparam int CLK_HALF  = 20;    // 40 ns period
   localparam int DRIVE_DLY = 2;     // ns after the rising edge
   localparam int SEED      = 86771;
   localparam int DIV_MIN   = DIV_RESET + 1; // random range stays off the reset value
   localparam int DIV_MAX   = 19;
   localparam int N_FRAMES  = 5;     // tx, rx, two back to back, soft clear
   localparam int MARGIN    = 2000;  // bus accesses, polling, reset
   localparam int TIMEOUT_CYCLES = N_FRAMES * 10 * DIV_MAX + MARGIN;

   // dut ports
   logic             clk;
   logic             rstn_int;
   logic             wb_cyc;
   logic             wb_stb;
   logic             wb_we;
   logic [3:0]       wb_adr;
   logic [WB_DW-1:0] wb_dat_i;
   logic [WB_DW-1:0] wb_dat_o;
   logic             wb_ack;
   logic             ser_tx;
   logic             ser_rx;

   int  cycle_cnt = 0;
   int  cur_div;          // divider the dut runs at now
   time last_ack_time;    // when the latest ack was seen
   time stop_seen_time;   // mid stop bit of the latest tx frame

   uart_top #(
      .DIV_W     (DIV_W),
      .DIV_RESET (DIV_RESET)
   ) uart_top_inst (
      .clk      (clk),
      .rstn_int (rstn_int),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack   (wb_ack),
      .ser_tx   (ser_tx),
      .ser_rx   (ser_rx)
   );

   `include "tb_uart_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // run length guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
         $display("Simulation failed");
         $fatal(1, "timeout: no end of the test sequence after %0d cycles", TIMEOUT_CYCLES);
      end
   end

   initial begin
      rstn_int = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_i = '0;
      ser_rx   = 1'b1;    // idle line
      cur_div  = DIV_RESET;
      last_ack_time  = 0;
      stop_seen_time = 0;
      void'($urandom(SEED));

      repeat (4) @(posedge clk);
      #DRIVE_DLY;
      rstn_int = 1'b1;

      read_reset_values();
      divider_readback();
      transmit_one_byte();
      receive_one_byte();
      back_to_back_writes();
      soft_clear_mid_frame();   // leaves divider at reset value

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire
